// ==== hdl/alu.sv ====
// combinational results for ADDI, OP group, LUI, AUIPC and BEQ/BNE; unsupported OP functs give zero
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire core_pkg::decoded_t dec,
    input  wire rv_isa_pkg::word_t  rs1_data,
    input  wire rv_isa_pkg::word_t  rs2_data,
    input  wire rv_isa_pkg::word_t  pc,
    output rv_isa_pkg::word_t       result,
    output logic                    taken,
    output rv_isa_pkg::word_t       eff_addr
);

    logic [4:0] shamt;

    assign shamt = rs2_data[4:0];

    // loads use the I immediate, stores the split S immediate
    assign eff_addr = rs1_data + ((dec.opcode == rv_isa_pkg::STORE) ? dec.s_imm : dec.i_imm);

    always_comb begin
        result = '0;
        case (dec.opcode)
            rv_isa_pkg::OPIMM: result = rs1_data + dec.i_imm;
            rv_isa_pkg::LUI:   result = dec.u_imm;
            rv_isa_pkg::AUIPC: result = pc + dec.u_imm;
            rv_isa_pkg::OP: begin
                case (dec.op_funct)
                    rv_isa_pkg::ADD:  result = rs1_data + rs2_data;
                    rv_isa_pkg::SUB:  result = rs1_data - rs2_data;
                    rv_isa_pkg::SLL:  result = rs1_data << shamt;
                    rv_isa_pkg::SLT:  result = rv_isa_pkg::word_t'($signed(rs1_data) < $signed(rs2_data));
                    rv_isa_pkg::SLTU: result = rv_isa_pkg::word_t'(rs1_data < rs2_data);
                    rv_isa_pkg::XOR:  result = rs1_data ^ rs2_data;
                    rv_isa_pkg::SRL:  result = rs1_data >> shamt;
                    // sign bit fills from the left
                    rv_isa_pkg::SRA:  result = $signed(rs1_data) >>> shamt;
                    rv_isa_pkg::OR:   result = rs1_data | rs2_data;
                    rv_isa_pkg::AND:  result = rs1_data & rs2_data;
                    rv_isa_pkg::MUL:  result = rs1_data * rs2_data;
                    default:          result = '0;
                endcase
            end
            default: result = '0;
        endcase
    end

    always_comb begin
        taken = 1'b0;
        if (dec.opcode == rv_isa_pkg::BRANCH) begin
            case (rv_isa_pkg::branch_funct_e'(dec.funct3))
                rv_isa_pkg::BEQ: taken = (rs1_data == rs2_data);
                rv_isa_pkg::BNE: taken = (rs1_data != rs2_data);
                default:         taken = 1'b0;
            endcase
        end
    end

    // a half-decoded OP word would silently produce zero
    always_comb begin
        if (dec.opcode == rv_isa_pkg::OP) begin
            a_op_funct_known: assert (!$isunknown(dec.op_funct));
        end
    end

endmodule

`default_nettype wire

// ==== hdl/core_control.sv ====
// one request outstanding at a time; stores to the I/O addresses never reach memory, halt holds until reset
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module core_control (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      mem_ack,
    input  wire core_pkg::decoded_t  live,
    input  wire core_pkg::decoded_t  held,
    input  wire rv_isa_pkg::word_t   mem_rd_data,
    input  wire rv_isa_pkg::word_t   result,
    input  wire                      taken,
    input  wire rv_isa_pkg::word_t   eff_addr,
    input  wire rv_isa_pkg::word_t   rs2_data,
    output rv_isa_pkg::word_t        pc,
    output rv_isa_pkg::instr_t       held_instr,
    output core_pkg::mem_req_t       mem_req,
    output core_pkg::wb_t            wb,
    output rv_isa_pkg::word_t        out,
    output logic                     out_valid,
    output logic                     halt
);

    core_pkg::phase_e   phase_q;
    core_pkg::phase_e   phase_d;
    rv_isa_pkg::word_t  pc_q;
    rv_isa_pkg::word_t  pc_d;
    rv_isa_pkg::word_t  next_pc;
    rv_isa_pkg::instr_t held_q;
    rv_isa_pkg::instr_t held_d;
    logic               armed_q;
    logic               do_fetch;

    assign pc         = pc_q;
    assign held_instr = held_q;
    assign halt       = (phase_q == core_pkg::HALTED);

    always_comb begin
        phase_d  = phase_q;
        pc_d     = pc_q;
        held_d   = held_q;
        next_pc  = pc_q + 32'd4;
        do_fetch = 1'b0;

        mem_req.rd_req  = 1'b0;
        mem_req.wr_req  = 1'b0;
        mem_req.addr    = eff_addr;
        mem_req.wr_data = rs2_data;

        wb.en   = 1'b0;
        wb.sel  = live.rd;
        wb.data = result;

        out       = rs2_data;
        out_valid = 1'b0;

        case (phase_q)
            core_pkg::FETCH: begin
                // first cycle after reset stays quiet
                if (armed_q) begin
                    next_pc  = pc_q;
                    do_fetch = 1'b1;
                end
            end
            core_pkg::EXEC: begin
                if (mem_ack) begin
                    case (live.opcode)
                        rv_isa_pkg::OPIMM, rv_isa_pkg::OP, rv_isa_pkg::LUI,
                        rv_isa_pkg::AUIPC: begin
                            wb.en    = 1'b1;
                            do_fetch = 1'b1;
                        end
                        rv_isa_pkg::BRANCH: begin
                            if (taken) begin
                                next_pc = pc_q + live.b_off;
                            end
                            do_fetch = 1'b1;
                        end
                        rv_isa_pkg::LOAD: begin
                            mem_req.rd_req = 1'b1;
                            held_d         = mem_rd_data;
                            phase_d        = core_pkg::MEM_WAIT;
                        end
                        rv_isa_pkg::STORE: begin
                            if (eff_addr == `RV_IO_OUT_ADDR) begin
                                out_valid = 1'b1;
                                do_fetch  = 1'b1;
                            end else if (eff_addr == `RV_IO_HALT_ADDR) begin
                                phase_d = core_pkg::HALTED;
                            end else begin
                                mem_req.wr_req = 1'b1;
                                held_d         = mem_rd_data;
                                phase_d        = core_pkg::MEM_WAIT;
                            end
                        end
                        default: phase_d = core_pkg::HALTED;
                    endcase
                end
            end
            core_pkg::MEM_WAIT: begin
                if (mem_ack) begin
                    wb.en    = (held.opcode == rv_isa_pkg::LOAD);
                    wb.sel   = held.rd;
                    wb.data  = mem_rd_data;
                    // cleared held word tells the top no access is pending
                    held_d   = '0;
                    do_fetch = 1'b1;
                end
            end
            default: begin
            end
        endcase

        if (do_fetch) begin
            pc_d           = next_pc;
            mem_req.rd_req = 1'b1;
            mem_req.addr   = next_pc;
            phase_d        = core_pkg::EXEC;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_q <= core_pkg::FETCH;
            pc_q    <= `RV_RESET_PC;
            held_q  <= '0;
            armed_q <= 1'b0;
        end else begin
            phase_q <= phase_d;
            pc_q    <= pc_d;
            held_q  <= held_d;
            armed_q <= 1'b1;
        end
    end

    a_one_req: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.rd_req && mem_req.wr_req));

    a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
        (phase_q == core_pkg::HALTED) |-> !(mem_req.rd_req || mem_req.wr_req));

endmodule

`default_nettype wire

// ==== hdl/core_pkg.sv ====
// control and datapath types for the multi-cycle core; depends on rv_isa_pkg being compiled first
`default_nettype none

package core_pkg;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM_WAIT,
        HALTED
    } phase_e;

    // all fields of one instruction, immediates already sign extended
    typedef struct packed {
        rv_isa_pkg::opcode_e   opcode;
        logic [2:0]            funct3;
        rv_isa_pkg::op_funct_e op_funct;
        rv_isa_pkg::reg_sel_t  rd;
        rv_isa_pkg::reg_sel_t  rs1;
        rv_isa_pkg::reg_sel_t  rs2;
        rv_isa_pkg::word_t     i_imm;
        rv_isa_pkg::word_t     s_imm;
        rv_isa_pkg::word_t     b_off;
        rv_isa_pkg::word_t     u_imm;
    } decoded_t;

    // request strobes are single-cycle pulses
    typedef struct packed {
        logic              rd_req;
        logic              wr_req;
        rv_isa_pkg::word_t addr;
        rv_isa_pkg::word_t wr_data;
    } mem_req_t;

    typedef struct packed {
        logic                 en;
        rv_isa_pkg::reg_sel_t sel;
        rv_isa_pkg::word_t    data;
    } wb_t;

endpackage

`default_nettype wire

// ==== hdl/instr_decode.sv ====
// purely combinational field split; no legality check here, unknown opcodes pass through unchanged
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
    input  wire rv_isa_pkg::instr_t instr,
    output core_pkg::decoded_t      dec
);

    always_comb begin
        dec.opcode   = rv_isa_pkg::opcode_e'(instr[6:0]);
        dec.funct3   = instr[14:12];
        dec.op_funct = rv_isa_pkg::op_funct_e'({instr[31:25], instr[14:12]});
        dec.rd       = instr[11:7];
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];

        dec.i_imm = {{20{instr[31]}}, instr[31:20]};
        dec.s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};

        // branch offset carries the implicit low zero bit
        dec.b_off = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

        dec.u_imm = {instr[31:12], 12'b0};
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
// two async read ports and one clocked write port; x0 reads zero and ignores writes
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module reg_file (
    input  wire                       clk,
    input  wire                       rst,
    input  wire rv_isa_pkg::reg_sel_t rs1_sel,
    input  wire rv_isa_pkg::reg_sel_t rs2_sel,
    output rv_isa_pkg::word_t         rs1_data,
    output rv_isa_pkg::word_t         rs2_data,
    input  wire core_pkg::wb_t        wb
);

    // x0 has no storage
    rv_isa_pkg::word_t regs [1:`RV_NUM_REGS-1];

    assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
    assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.sel != '0)) begin
            regs[wb.sel] <= wb.data;
        end
    end

    a_wb_en_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(wb.en));

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
// memory must answer every request with one ack pulse and keep mem_rd_data valid during that ack
`timescale 1ns/1ns
`default_nettype none

module rv_core (
    input  wire                    clk,
    input  wire                    rst,
    output core_pkg::mem_req_t     mem_req,
    input  wire                    mem_ack,
    input  wire rv_isa_pkg::word_t mem_rd_data,
    output rv_isa_pkg::word_t      out,
    output logic                   out_valid,
    output logic                   halt
);

    rv_isa_pkg::instr_t held_instr;
    core_pkg::decoded_t live_dec;
    core_pkg::decoded_t held_dec;
    core_pkg::decoded_t cur_dec;
    logic               use_held;
    rv_isa_pkg::word_t  rs1_data;
    rv_isa_pkg::word_t  rs2_data;
    rv_isa_pkg::word_t  pc;
    rv_isa_pkg::word_t  result;
    rv_isa_pkg::word_t  eff_addr;
    logic               taken;
    core_pkg::wb_t      wb;

    // a load or store in the held word means MEM_WAIT
    assign use_held = held_dec.opcode inside {rv_isa_pkg::LOAD, rv_isa_pkg::STORE};
    assign cur_dec  = use_held ? held_dec : live_dec;

    instr_decode u_live_dec (
        .instr (mem_rd_data),
        .dec   (live_dec)
    );

    instr_decode u_held_dec (
        .instr (held_instr),
        .dec   (held_dec)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (cur_dec.rs1),
        .rs2_sel  (cur_dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    alu u_alu (
        .dec      (cur_dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (pc),
        .result   (result),
        .taken    (taken),
        .eff_addr (eff_addr)
    );

    core_control u_control (
        .clk         (clk),
        .rst         (rst),
        .mem_ack     (mem_ack),
        .live        (live_dec),
        .held        (held_dec),
        .mem_rd_data (mem_rd_data),
        .result      (result),
        .taken       (taken),
        .eff_addr    (eff_addr),
        .rs2_data    (rs2_data),
        .pc          (pc),
        .held_instr  (held_instr),
        .mem_req     (mem_req),
        .wb          (wb),
        .out         (out),
        .out_valid   (out_valid),
        .halt        (halt)
    );

endmodule

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
// RV32I subset plus MUL only; no DIV/REM encodings and no compressed instructions
`default_nettype none

`include "rv_params.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_sel_t;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPIMM  = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // OP group selector as {funct7, funct3}
    typedef enum logic [9:0] {
        ADD  = 10'b0000000_000,
        SUB  = 10'b0100000_000,
        SLL  = 10'b0000000_001,
        SLT  = 10'b0000000_010,
        SLTU = 10'b0000000_011,
        XOR  = 10'b0000000_100,
        SRL  = 10'b0000000_101,
        SRA  = 10'b0100000_101,
        OR   = 10'b0000000_110,
        AND  = 10'b0000000_111,
        MUL  = 10'b0000001_000
    } op_funct_e;

    typedef enum logic [2:0] {
        BEQ = 3'b000,
        BNE = 3'b001
    } branch_funct_e;

endpackage

`default_nettype wire

// ==== hdl/rv_params.svh ====
// fixed build-time values; the two I/O addresses are word aligned and must lie outside program memory
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers including x0
`define RV_NUM_REGS 32

// first fetch after reset
`define RV_RESET_PC 32'd0

// store here to drive the output port
`define RV_IO_OUT_ADDR 32'd1000

// store here to stop the core until reset
`define RV_IO_HALT_ADDR 32'd1004

`endif

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_rv_core -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Testbench passed" "$LOG"; then
    echo "no pass line found in $LOG"
    exit 1
fi

exit 0

// ==== sources.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/instr_decode.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/core_control.sv
hdl/rv_core.sv
testbench/tb_mem_model.sv
testbench/tb_rv_core.sv

// ==== testbench/tb_mem_model.sv ====
// 64-word memory, addresses wrap on bits [7:2]; ack comes 1 to 4 cycles after a request
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model #(
    parameter int unsigned seed = 32'd1
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire core_pkg::mem_req_t req,
    output logic                    ack,
    output rv_isa_pkg::word_t       rd_data,
    input  wire                     load_en,
    input  wire [5:0]               load_idx,
    input  wire rv_isa_pkg::word_t  load_data
);

    rv_isa_pkg::word_t mem [0:63];
    logic              busy;
    logic              is_write;
    logic [2:0]        remaining;
    logic [1:0]        wait_cycles;
    logic [5:0]        idx;
    logic              do_write;

    // a write lands on the edge that takes the request
    assign do_write = !busy && req.wr_req;

    always @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (do_write) begin
            mem[req.addr[7:2]] <= req.wr_data;
        end
    end

    initial begin
        ack     <= 1'b0;
        rd_data <= '0;
        void'($urandom(seed));
        forever begin
            @(posedge clk or posedge rst);
            if (rst) begin
                ack       <= 1'b0;
                busy      <= 1'b0;
                is_write  <= 1'b0;
                remaining <= 3'd0;
                idx       <= '0;
                rd_data   <= '0;
            end else begin
                ack <= 1'b0;
                if (busy) begin
                    if (remaining == 3'd1) begin
                        ack  <= 1'b1;
                        busy <= 1'b0;
                        if (!is_write) begin
                            rd_data <= mem[idx];
                        end
                    end else begin
                        remaining <= remaining - 3'd1;
                    end
                end else if (req.rd_req || req.wr_req) begin
                    // no extra wait means the ack follows in the next cycle
                    wait_cycles = 2'($urandom % 4);
                    is_write   <= req.wr_req;
                    idx        <= req.addr[7:2];
                    if (wait_cycles == 2'd0) begin
                        ack <= 1'b1;
                        if (!req.wr_req) begin
                            rd_data <= mem[req.addr[7:2]];
                        end
                    end else begin
                        busy      <= 1'b1;
                        remaining <= 3'(wait_cycles);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_rv_core.sv ====
// every program must end in a halt; programs are loaded at address 0 and fit in 64 words
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

    logic               clk;
    logic               rst;
    core_pkg::mem_req_t mem_req;
    logic               mem_ack;
    rv_isa_pkg::word_t  mem_rd_data;
    rv_isa_pkg::word_t  out;
    logic               out_valid;
    logic               halt;
    logic               load_en;
    logic [5:0]         load_idx;
    rv_isa_pkg::word_t  load_data;

    rv_isa_pkg::instr_t prog_mem [0:127];
    rv_isa_pkg::word_t  exp_out [0:63];
    string              test_name [0:7];
    int                 prog_start [0:7];
    int                 prog_len [0:7];
    int                 exp_start [0:7];
    int                 exp_cnt [0:7];
    int                 n_tests;
    int                 n_instr;
    int                 n_exp;
    int                 err_count;
    int                 failed_tests;
    int                 cycles;
    int                 cycle_limit;
    logic               running;

    rv_core DUT (
        .clk         (clk),
        .rst         (rst),
        .mem_req     (mem_req),
        .mem_ack     (mem_ack),
        .mem_rd_data (mem_rd_data),
        .out         (out),
        .out_valid   (out_valid),
        .halt        (halt)
    );

    tb_mem_model #(
        .seed (32'h092e_4a32)
    ) u_mem (
        .clk       (clk),
        .rst       (rst),
        .req       (mem_req),
        .ack       (mem_ack),
        .rd_data   (mem_rd_data),
        .load_en   (load_en),
        .load_idx  (load_idx),
        .load_data (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // instruction encoders, field layout from the RV32I base formats
    function automatic rv_isa_pkg::instr_t addi_instr(input logic [4:0] rd,
                                                     input logic [4:0] rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic rv_isa_pkg::instr_t load_instr(input logic [4:0] rd,
                                                     input logic [4:0] rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic rv_isa_pkg::instr_t store_instr(input logic [4:0] rs2,
                                                      input logic [4:0] rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], rs2, rs1, 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic rv_isa_pkg::instr_t branch_instr(input logic [2:0] f3,
                                                       input logic [4:0] rs1,
                                                       input logic [4:0] rs2, input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic rv_isa_pkg::instr_t upper_instr(input logic [6:0] opc,
                                                      input logic [4:0] rd,
                                                      input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic rv_isa_pkg::instr_t rtype_instr(input logic [9:0] f,
                                                      input logic [4:0] rd,
                                                      input logic [4:0] rs1,
                                                      input logic [4:0] rs2);
        return {f[9:3], rs2, rs1, f[2:0], rd, 7'b0110011};
    endfunction

    task automatic start_test(input string name);
        test_name[n_tests]  = name;
        prog_start[n_tests] = n_instr;
        prog_len[n_tests]   = 0;
        exp_start[n_tests]  = n_exp;
        exp_cnt[n_tests]    = 0;
        n_tests++;
    endtask

    task automatic push_instr(input rv_isa_pkg::instr_t w);
        prog_mem[n_instr] = w;
        n_instr++;
        prog_len[n_tests-1]++;
    endtask

    task automatic push_out(input rv_isa_pkg::word_t v);
        exp_out[n_exp] = v;
        n_exp++;
        exp_cnt[n_tests-1]++;
    endtask

    // x3 = x1 op x2, then sent to the output port
    task automatic push_op(input logic [9:0] f, input rv_isa_pkg::word_t v);
        push_instr(rtype_instr(f, 5'd3, 5'd1, 5'd2));
        push_instr(store_instr(5'd3, 5'd0, 1000));
        push_out(v);
    endtask

    task automatic build_table();
        start_test("addi lui auipc");
        push_instr(addi_instr(5'd1, 5'd0, -5));
        push_instr(store_instr(5'd1, 5'd0, 1000));
        push_instr(upper_instr(7'b0110111, 5'd2, 20'h12345));
        push_instr(store_instr(5'd2, 5'd0, 1000));
        // pc 16 plus 0x1000
        push_instr(upper_instr(7'b0010111, 5'd3, 20'h00001));
        push_instr(store_instr(5'd3, 5'd0, 1000));
        push_instr(store_instr(5'd0, 5'd0, 1004));
        push_out(32'hFFFF_FFFB);
        push_out(32'h1234_5000);
        push_out(32'h0000_1010);

        // x1 = -20, x2 = 3
        start_test("op group");
        push_instr(addi_instr(5'd1, 5'd0, -20));
        push_instr(addi_instr(5'd2, 5'd0, 3));
        push_op(rv_isa_pkg::ADD, 32'hFFFF_FFEF);
        push_op(rv_isa_pkg::SUB, 32'hFFFF_FFE9);
        push_op(rv_isa_pkg::SLT, 32'h0000_0001);
        push_op(rv_isa_pkg::SLTU, 32'h0000_0000);
        push_op(rv_isa_pkg::AND, 32'h0000_0000);
        push_op(rv_isa_pkg::OR, 32'hFFFF_FFEF);
        push_op(rv_isa_pkg::XOR, 32'hFFFF_FFEF);
        push_op(rv_isa_pkg::SLL, 32'hFFFF_FF60);
        push_op(rv_isa_pkg::SRL, 32'h1FFF_FFFD);
        push_op(rv_isa_pkg::SRA, 32'hFFFF_FFFD);
        push_op(rv_isa_pkg::MUL, 32'hFFFF_FFC4);
        push_instr(store_instr(5'd0, 5'd0, 1004));

        start_test("store load x0");
        push_instr(addi_instr(5'd1, 5'd0, 32'h5A5));
        push_instr(addi_instr(5'd5, 5'd0, 200));
        push_instr(store_instr(5'd1, 5'd5, 0));
        push_instr(load_instr(5'd2, 5'd5, 0));
        push_instr(store_instr(5'd2, 5'd0, 1000));
        push_instr(addi_instr(5'd0, 5'd0, 7));
        push_instr(store_instr(5'd0, 5'd0, 1000));
        push_instr(load_instr(5'd0, 5'd5, 0));
        push_instr(store_instr(5'd0, 5'd0, 1000));
        push_instr(addi_instr(5'd3, 5'd0, -2));
        push_instr(store_instr(5'd3, 5'd5, 4));
        push_instr(load_instr(5'd4, 5'd5, 4));
        push_instr(store_instr(5'd4, 5'd0, 1000));
        push_instr(store_instr(5'd0, 5'd0, 1004));
        push_out(32'h0000_05A5);
        push_out(32'h0000_0000);
        push_out(32'h0000_0000);
        push_out(32'hFFFF_FFFE);

        // countdown loop, then a taken BEQ skips marker 0x11, a not-taken BNE reaches 0x22
        start_test("branches");
        push_instr(addi_instr(5'd1, 5'd0, 3));
        push_instr(store_instr(5'd1, 5'd0, 1000));
        push_instr(addi_instr(5'd1, 5'd1, -1));
        push_instr(branch_instr(3'b001, 5'd1, 5'd0, -8));
        push_instr(addi_instr(5'd2, 5'd0, 32'h11));
        push_instr(branch_instr(3'b000, 5'd1, 5'd0, 8));
        push_instr(store_instr(5'd2, 5'd0, 1000));
        push_instr(addi_instr(5'd3, 5'd0, 32'h22));
        push_instr(branch_instr(3'b001, 5'd1, 5'd0, 8));
        push_instr(store_instr(5'd3, 5'd0, 1000));
        push_instr(store_instr(5'd0, 5'd0, 1004));
        push_out(32'd3);
        push_out(32'd2);
        push_out(32'd1);
        push_out(32'h22);

        start_test("unknown opcode");
        push_instr(addi_instr(5'd1, 5'd0, 9));
        push_instr(store_instr(5'd1, 5'd0, 1000));
        push_instr(32'h0000_007F);
        push_instr(store_instr(5'd1, 5'd0, 1000));
        push_out(32'd9);
    endtask

    task automatic check_word(input string name, input rv_isa_pkg::word_t got,
                              input rv_isa_pkg::word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b, expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < 64; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_idx  <= 6'(i);
            // spare words hold their own index above an unknown opcode
            load_data <= (i < prog_len[t]) ? prog_mem[prog_start[t] + i]
                                           : {25'(i), 7'b1111111};
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic run_test(input int t);
        int n;
        int errs_before;
        n           = 0;
        errs_before = err_count;
        load_program(t);
        @(posedge clk);
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst     <= 1'b0;
        running <= 1'b1;
        @(negedge clk);
        check_flag("halt", halt, 1'b0);
        while (!halt) begin
            @(negedge clk);
            if (out_valid) begin
                if (n < exp_cnt[t]) begin
                    check_word("out", out, exp_out[exp_start[t] + n]);
                end else begin
                    $display("extra output %h at %0t beyond the expected list", out, $time);
                    err_count++;
                end
                n++;
            end
        end
        if (n < exp_cnt[t]) begin
            $display("only %0d of %0d outputs seen before halt", n, exp_cnt[t]);
            err_count++;
        end
        // halted core stays quiet
        repeat (5) begin
            @(negedge clk);
            check_flag("halt", halt, 1'b1);
            check_flag("mem_req.rd_req", mem_req.rd_req, 1'b0);
            check_flag("mem_req.wr_req", mem_req.wr_req, 1'b0);
        end
        running = 1'b0;
        if (err_count == errs_before) begin
            $display("test %0d (%s): ok, %0d outputs", t, test_name[t], n);
        end else begin
            $display("test %0d (%s): FAIL, %0d errors", t, test_name[t], err_count - errs_before);
            failed_tests++;
        end
    endtask

    always @(posedge clk) begin
        if (running) begin
            cycles++;
            if (cycles > cycle_limit) begin
                $display("timeout after %0d run cycles, the core never halted", cycles);
                $display("Testbench failed");
                $finish;
            end
        end
    end

    initial begin
        rst          = 1'b1;
        load_en      = 1'b0;
        load_idx     = '0;
        load_data    = '0;
        running      = 1'b0;
        cycles       = 0;
        n_tests      = 0;
        n_instr      = 0;
        n_exp        = 0;
        err_count    = 0;
        failed_tests = 0;
        build_table();
        // latency bound 4 plus two phases, with a factor of two margin
        cycle_limit = n_instr * (4 + 2) * 2;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("tests %0d, failed %0d, check errors %0d", n_tests, failed_tests, err_count);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
